//--- list.f
+incdir+source
source/cache_pkg.sv
source/cache_line_store.sv
source/icache_core.sv
source/dcache_core.sv
source/mem_bus_arbiter.sv
source/cache_unit.sv
test/tb_mem_model.sv
test/tb_cache_unit.sv

//--- Bender.yml
package:
  name: cache_unit

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/cache_line_store.sv
      - source/icache_core.sv
      - source/dcache_core.sv
      - source/mem_bus_arbiter.sv
      - source/cache_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_mem_model.sv
      - test/tb_cache_unit.sv

//--- test/tb_cache_unit.sv
/* Testbench for the cache unit. Code and data use separate address regions, and a
   data access never crosses a doubleword. Memory starts with a pattern of the address. */

`include "cache_params.svh"

module tb_cache_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  localparam addr_t INST_BASE      = 64'h0000_0000_0001_0000;
  localparam addr_t DATA_BASE      = 64'h0000_0000_8000_0000;
  localparam int    TIMEOUT_CYCLES = 12000;  // About 600 requests of up to about 16 cycles

  logic        clk = 1'b0;
  logic        rst;
  logic        icache_req;
  addr_t       icache_addr;
  logic        icache_ack;
  inst_t       icache_rdata;
  logic        dcache_req;
  addr_t       dcache_addr;
  logic        dcache_op;
  logic [2:0]  dcache_bytes;
  dword_t      dcache_wdata;
  logic        dcache_ack;
  dword_t      dcache_rdata;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  line_t       fill_line;
  logic [1:0]  mem_latency;
  logic        mem_error;
  logic [15:0] rng_q = 16'd82;
  logic [7:0]  shadow [addr_t];
  int          cycles = 0;
  int          evictions = 0;

  always #2 clk = ~clk;

  cache_unit u_dut (
    .clk            (clk),
    .i_rst          (rst),
    .i_icache_req   (icache_req),
    .i_icache_addr  (icache_addr),
    .o_icache_ack   (icache_ack),
    .o_icache_rdata (icache_rdata),
    .i_dcache_req   (dcache_req),
    .i_dcache_addr  (dcache_addr),
    .i_dcache_op    (dcache_op),
    .i_dcache_bytes (dcache_bytes),
    .i_dcache_wdata (dcache_wdata),
    .o_dcache_ack   (dcache_ack),
    .o_dcache_rdata (dcache_rdata),
    .o_mem_req      (mem_req),
    .i_mem_rsp      (mem_rsp)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .i_rst       (rst),
    .i_req       (mem_req),
    .o_rsp       (mem_rsp),
    .i_fill_line (fill_line),
    .i_latency   (mem_latency),
    .o_error     (mem_error)
  );

  // ==================================================
  // Random numbers, memory pattern and reference model
  // ==================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v     = {v[62:0], rng_q[0]};
      rng_q = lfsr_step(rng_q);
    end
    return v;
  endfunction

  function automatic logic [7:0] pattern_byte(input addr_t a);
    logic [7:0] b;
    b = 8'h5a;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], b[7]} ^ a[i*8 +: 8];   // Every address byte feeds the pattern
    end
    return b;
  endfunction

  function automatic logic [7:0] shadow_byte(input addr_t a);
    return shadow.exists(a) ? shadow[a] : pattern_byte(a);
  endfunction

  // Byte 0 of a line sits in the low bits
  function automatic line_t line_of(input addr_t a, input logic from_shadow);
    line_t l;
    for (int i = 0; i < `LINE_BYTES; i++) begin
      l[i*8 +: 8] = from_shadow ? shadow_byte(a + i) : pattern_byte(a + i);
    end
    return l;
  endfunction

  // Byte i of the result is the byte at a+i up to the access size
  function automatic dword_t load_reference(input addr_t a, input logic [2:0] n);
    dword_t d;
    d = '0;
    for (int i = 0; i <= n; i++) begin
      d[i*8 +: 8] = shadow_byte(a + i);
    end
    return d;
  endfunction

  function automatic inst_t fetch_reference(input addr_t a);
    addr_t w;
    w = {a[63:2], 2'b00};
    return {shadow_byte(w + 3), shadow_byte(w + 2), shadow_byte(w + 1), shadow_byte(w)};
  endfunction

  assign fill_line = line_of(mem_req.addr, 1'b0);

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [511:0] got,
                                 input logic [511:0] exp);
    stop_with_failure($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
  endtask

  task automatic check_quiet();
    assert (icache_ack === 1'b0 && dcache_ack === 1'b0 && mem_req.valid === 1'b0)
      else stop_with_failure("An ack or a memory request was active in or just after reset");
  endtask

  // ==================================================
  // Comparing process and timeout
  // ==================================================
  always @(posedge clk) begin
    cycles <= cycles + 1;
    assert (cycles < TIMEOUT_CYCLES)
      else stop_with_failure("Timeout: the requests did not finish within the cycle limit");
    assert (mem_error !== 1'b1)
      else stop_with_failure("The memory model saw a bus protocol violation");
    if (icache_ack === 1'b1) begin
      assert (icache_rdata === fetch_reference(icache_addr))
        else report_mismatch("o_icache_rdata", icache_rdata, fetch_reference(icache_addr));
    end
    if (dcache_ack === 1'b1) begin
      assert (dcache_rdata === load_reference(dcache_addr, dcache_bytes))
        else report_mismatch("o_dcache_rdata", dcache_rdata,
                             load_reference(dcache_addr, dcache_bytes));
      if (dcache_op == `MEM_OP_WRITE) begin
        for (int i = 0; i <= dcache_bytes; i++) begin
          shadow[dcache_addr + i] = dcache_wdata[i*8 +: 8];
        end
      end
    end
    if (mem_req.valid && mem_rsp.ready && mem_req.op == `MEM_OP_WRITE) begin
      assert (mem_req.wdata === line_of(mem_req.addr, 1'b1))
        else report_mismatch("o_mem_req.wdata", mem_req.wdata, line_of(mem_req.addr, 1'b1));
      evictions++;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic fetch(input addr_t a, input logic expect_hit);
    int lat;
    icache_addr = a;
    icache_req  = 1'b1;
    lat         = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (icache_ack !== 1'b1);
    if (expect_hit) begin
      assert (lat == 1) else report_mismatch("o_icache_ack latency", lat, 1);
    end
    @(negedge clk);                       // Fields stay stable until RESPOND ends
    icache_req = 1'b0;
  endtask

  task automatic access(input addr_t a, input logic op, input logic [2:0] n, input dword_t wd);
    dcache_addr  = a;
    dcache_op    = op;
    dcache_bytes = n;
    dcache_wdata = wd;
    dcache_req   = 1'b1;
    do begin
      @(negedge clk);
    end while (dcache_ack !== 1'b1);
    @(negedge clk);
    dcache_req = 1'b0;
  endtask

  task automatic random_access();
    addr_t      a;
    logic [2:0] off;
    logic [2:0] n;
    logic       op;
    a   = DATA_BASE + (rand_bits(2) << 10);   // Four tags compete for each index
    a   = a + (rand_bits(7) << 3);
    off = 3'(rand_bits(3));
    n   = 3'(rand_bits(3));
    if (off + n > 7) begin
      n = 3'd7 - off;                         // Stay inside the doubleword
    end
    op          = 1'(rand_bits(1));
    mem_latency = 2'(rand_bits(2));
    access(a + off, op, n, rand_bits(64));
  endtask

  initial begin
    addr_t ia;
    rst          = 1'b1;
    icache_req   = 1'b0;
    icache_addr  = '0;
    dcache_req   = 1'b0;
    dcache_addr  = '0;
    dcache_op    = 1'b0;
    dcache_bytes = '0;
    dcache_wdata = '0;
    mem_latency  = '0;
    repeat (8) begin
      @(negedge clk);
      check_quiet();
    end
    rst = 1'b0;
    @(negedge clk);
    check_quiet();

    repeat (64) begin
      ia          = INST_BASE + (rand_bits(2) << 10);
      ia          = ia + (rand_bits(8) << 2);
      mem_latency = 2'(rand_bits(2));
      fetch(ia, 1'b0);
      fetch(ia, 1'b1);                    // Line was just filled
    end

    repeat (300) random_access();

    repeat (80) begin
      ia = INST_BASE + (rand_bits(2) << 10);
      ia = ia + (rand_bits(8) << 2);
      fork
        fetch(ia, 1'b0);
        random_access();
      join
    end

    assert (evictions > 0) else stop_with_failure("No dirty eviction reached the memory bus");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- test/tb_mem_model.sv
/* Line-wide memory on the cache unit's bus. Lines never written come from i_fill_line.
   Ready follows 1 to 4 cycles after valid is first seen; bus protocol errors raise o_error. */

`include "cache_params.svh"

module tb_mem_model (
  input  logic                clk,
  input  logic                i_rst,
  input  cache_pkg::mem_req_t i_req,
  output cache_pkg::mem_rsp_t o_rsp,
  input  cache_pkg::line_t    i_fill_line,
  input  logic [1:0]          i_latency,
  output logic                o_error
);

  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  line_t    mem [addr_t];
  mem_req_t held;
  logic     busy;
  logic     after_ready;
  int       wait_cycles;

  initial begin
    o_rsp       = '0;
    o_error     = 1'b0;
    busy        = 1'b0;
    after_ready = 1'b0;
  end

  task automatic flag_error(input string what);
    $display("Memory model at %0d ns: %s", $time, what);
    o_error = 1'b1;
  endtask

  // ==================================================
  // Bus responder driven on the falling edge
  // ==================================================
  always @(negedge clk) begin
    o_rsp = '0;
    if (i_rst) begin
      busy        = 1'b0;
      after_ready = 1'b0;
    end else if (after_ready) begin
      assert (i_req.valid === 1'b0) else flag_error("valid stayed high after ready");
      after_ready = 1'b0;
    end else if (busy) begin
      assert (i_req === held) else flag_error("op, addr or wdata changed while valid was high");
      if (wait_cycles == 0) begin
        o_rsp.ready = 1'b1;
        if (held.op == `MEM_OP_WRITE) begin
          mem[held.addr] = held.wdata;
        end else begin
          o_rsp.rdata = mem.exists(held.addr) ? mem[held.addr] : i_fill_line;
        end
        busy        = 1'b0;
        after_ready = 1'b1;
      end else begin
        wait_cycles--;
      end
    end else if (i_req.valid === 1'b1) begin
      assert (i_req.addr % `LINE_BYTES == 0) else flag_error("address is not line aligned");
      held        = i_req;
      busy        = 1'b1;
      wait_cycles = i_latency;            // Ready comes 1 to 4 cycles later
    end
  end

endmodule

//--- source/cache_unit.sv
/* L1 cache unit with split instruction and data caches on one memory port.
   Code and data must live in separate regions, the caches are not coherent. */

module cache_unit (
  input  logic                clk,
  input  logic                i_rst,

  input  logic                i_icache_req,
  input  cache_pkg::addr_t    i_icache_addr,
  output logic                o_icache_ack,
  output cache_pkg::inst_t    o_icache_rdata,

  input  logic                i_dcache_req,
  input  cache_pkg::addr_t    i_dcache_addr,
  input  logic                i_dcache_op,
  input  logic [2:0]          i_dcache_bytes,
  input  cache_pkg::dword_t   i_dcache_wdata,
  output logic                o_dcache_ack,
  output cache_pkg::dword_t   o_dcache_rdata,

  output cache_pkg::mem_req_t o_mem_req,
  input  cache_pkg::mem_rsp_t i_mem_rsp
);

  import cache_pkg::*;

  mem_req_t icache_mem_req;
  mem_req_t dcache_mem_req;
  mem_rsp_t icache_mem_rsp;
  mem_rsp_t dcache_mem_rsp;

  icache_core u_icache (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (i_icache_req),
    .i_addr    (i_icache_addr),
    .o_ack     (o_icache_ack),
    .o_rdata   (o_icache_rdata),
    .o_mem_req (icache_mem_req),
    .i_mem_rsp (icache_mem_rsp)
  );

  dcache_core u_dcache (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (i_dcache_req),
    .i_addr    (i_dcache_addr),
    .i_op      (i_dcache_op),
    .i_bytes   (i_dcache_bytes),
    .i_wdata   (i_dcache_wdata),
    .o_ack     (o_dcache_ack),
    .o_rdata   (o_dcache_rdata),
    .o_mem_req (dcache_mem_req),
    .i_mem_rsp (dcache_mem_rsp)
  );

  mem_bus_arbiter u_arbiter (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_icache_req (icache_mem_req),
    .i_dcache_req (dcache_mem_req),
    .o_icache_rsp (icache_mem_rsp),
    .o_dcache_rsp (dcache_mem_rsp),
    .o_mem_req    (o_mem_req),
    .i_mem_rsp    (i_mem_rsp)
  );

endmodule

//--- source/mem_bus_arbiter.sv
/* Shares one memory port between the two caches, one line transfer at a time.
   A grant costs one idle cycle before the transfer and one after ready. */

module mem_bus_arbiter (
  input  logic                clk,
  input  logic                i_rst,
  input  cache_pkg::mem_req_t i_icache_req,
  input  cache_pkg::mem_req_t i_dcache_req,
  output cache_pkg::mem_rsp_t o_icache_rsp,
  output cache_pkg::mem_rsp_t o_dcache_rsp,
  output cache_pkg::mem_req_t o_mem_req,
  input  cache_pkg::mem_rsp_t i_mem_rsp
);

  import cache_pkg::*;

  typedef enum logic [1:0] {GNT_NONE, GNT_ICACHE, GNT_DCACHE} grant_t;

  grant_t grant_q;
  logic   last_dcache_q;      // Set when the data cache was served last

  always_ff @(posedge clk) begin
    if (i_rst) begin
      grant_q       <= GNT_NONE;
      last_dcache_q <= 1'b0;
    end else if (grant_q == GNT_NONE) begin
      if (i_icache_req.valid && (!i_dcache_req.valid || last_dcache_q)) begin
        grant_q       <= GNT_ICACHE;
        last_dcache_q <= 1'b0;
      end else if (i_dcache_req.valid) begin
        grant_q       <= GNT_DCACHE;
        last_dcache_q <= 1'b1;
      end
    end else if (i_mem_rsp.ready) begin
      grant_q <= GNT_NONE;
    end
  end

  // ==================================================
  // Request and response routing
  // ==================================================
  always_comb begin
    o_mem_req    = '0;
    o_icache_rsp = '0;
    o_dcache_rsp = '0;
    case (grant_q)
      GNT_ICACHE: begin
        o_mem_req    = i_icache_req;
        o_icache_rsp = i_mem_rsp;
      end
      GNT_DCACHE: begin
        o_mem_req    = i_dcache_req;
        o_dcache_rsp = i_mem_rsp;
      end
      default: begin
        o_mem_req = '0;
      end
    endcase
  end

endmodule

//--- source/dcache_core.sv
/* Write-back, write-allocate data cache. Accesses of i_bytes+1 bytes must not
   cross an aligned doubleword. Request fields must stay stable until the ack. */

`include "cache_params.svh"

module dcache_core (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_req,
  input  cache_pkg::addr_t    i_addr,
  input  logic                i_op,
  input  logic [2:0]          i_bytes,
  input  cache_pkg::dword_t   i_wdata,
  output logic                o_ack,
  output cache_pkg::dword_t   o_rdata,
  output cache_pkg::mem_req_t o_mem_req,
  input  cache_pkg::mem_rsp_t i_mem_rsp
);

  import cache_pkg::*;

  dcache_state_t state_q;
  dcache_state_t state_d;
  tag_t          req_tag;
  index_t        req_index;
  offset_t       req_offset;
  line_meta_t    meta;
  line_meta_t    wr_meta;
  line_t         cur_line;
  line_t         wr_line;
  line_t         merged_line;
  logic          wr_en;
  logic          hit;
  logic          is_write;
  logic [8:0]    dword_lsb;
  logic [5:0]    byte_shift;
  dword_t        byte_mask;
  dword_t        old_dword;
  dword_t        new_dword;

  assign {req_tag, req_index, req_offset} = i_addr;

  assign hit      = meta.valid && (meta.tag == req_tag);
  assign is_write = (i_op == `MEM_OP_WRITE);

  // ==================================================
  // Byte lane read and store merge
  // ==================================================
  assign dword_lsb  = {req_offset[OFFSET_W-1:3], 6'b0};
  assign byte_shift = {req_offset[2:0], 3'b0};
  assign byte_mask  = {64{1'b1}} >> {~i_bytes, 3'b0};   // Low i_bytes+1 bytes set
  assign old_dword  = cur_line[dword_lsb +: 64];
  assign new_dword  = (old_dword & ~(byte_mask << byte_shift)) |
                      ((i_wdata & byte_mask) << byte_shift);

  always_comb begin
    merged_line                   = cur_line;
    merged_line[dword_lsb +: 64]  = new_dword;
  end

  // Store is read before the RESPOND write lands, so this is the pre-write value
  assign o_rdata = (old_dword >> byte_shift) & byte_mask;
  assign o_ack   = (state_q == DC_RESPOND);

  // ==================================================
  // Line store and its write port
  // ==================================================
  always_comb begin
    wr_en         = 1'b0;
    wr_meta       = '0;
    wr_meta.valid = 1'b1;
    wr_meta.tag   = req_tag;
    wr_line       = i_mem_rsp.rdata;
    if ((state_q == DC_FILL) && i_mem_rsp.ready) begin
      wr_en = 1'b1;                     // Fresh line is clean
    end else if ((state_q == DC_RESPOND) && is_write) begin
      wr_en         = 1'b1;
      wr_meta.dirty = 1'b1;
      wr_line       = merged_line;
    end
  end

  cache_line_store u_store (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_index   (req_index),
    .o_meta    (meta),
    .o_line    (cur_line),
    .i_wr_en   (wr_en),
    .i_wr_meta (wr_meta),
    .i_wr_line (wr_line)
  );

  // ==================================================
  // Controller
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      DC_IDLE: begin
        if (i_req) begin
          if (hit) begin
            state_d = DC_RESPOND;
          end else if (meta.valid && meta.dirty) begin
            state_d = DC_EVICT;
          end else begin
            state_d = DC_FILL;
          end
        end
      end
      DC_EVICT: begin
        if (i_mem_rsp.ready) begin
          state_d = DC_FILL;
        end
      end
      DC_FILL: begin
        if (i_mem_rsp.ready) begin
          state_d = DC_RESPOND;
        end
      end
      default: begin
        state_d = DC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= DC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    o_mem_req       = '0;
    o_mem_req.op    = `MEM_OP_READ;
    o_mem_req.addr  = {req_tag, req_index, {OFFSET_W{1'b0}}};
    if (state_q == DC_EVICT) begin
      o_mem_req.valid = 1'b1;
      o_mem_req.op    = `MEM_OP_WRITE;
      o_mem_req.addr  = {meta.tag, req_index, {OFFSET_W{1'b0}}};  // Victim address
      o_mem_req.wdata = cur_line;
    end else if (state_q == DC_FILL) begin
      o_mem_req.valid = 1'b1;
    end
  end

endmodule

//--- source/icache_core.sv
/* Read-only instruction cache. i_addr must stay stable from request to ack.
   Instructions are 32 bits and word aligned; the two low address bits are ignored. */

`include "cache_params.svh"

module icache_core (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_req,
  input  cache_pkg::addr_t    i_addr,
  output logic                o_ack,
  output cache_pkg::inst_t    o_rdata,
  output cache_pkg::mem_req_t o_mem_req,
  input  cache_pkg::mem_rsp_t i_mem_rsp
);

  import cache_pkg::*;

  icache_state_t state_q;
  icache_state_t state_d;
  tag_t          req_tag;
  index_t        req_index;
  offset_t       req_offset;
  line_meta_t    meta;
  line_meta_t    fill_meta;
  line_t         cur_line;
  logic          hit;
  logic          fill_done;

  assign {req_tag, req_index, req_offset} = i_addr;

  assign hit       = meta.valid && (meta.tag == req_tag);
  assign fill_done = (state_q == IC_FILL) && i_mem_rsp.ready;

  always_comb begin
    fill_meta       = '0;
    fill_meta.valid = 1'b1;             // Filled lines are never dirty
    fill_meta.tag   = req_tag;
  end

  cache_line_store u_store (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_index   (req_index),
    .o_meta    (meta),
    .o_line    (cur_line),
    .i_wr_en   (fill_done),
    .i_wr_meta (fill_meta),
    .i_wr_line (i_mem_rsp.rdata)
  );

  // ==================================================
  // Controller
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IC_IDLE: begin
        if (i_req) begin
          state_d = hit ? IC_RESPOND : IC_FILL;
        end
      end
      IC_FILL: begin
        if (i_mem_rsp.ready) begin
          state_d = IC_RESPOND;
        end
      end
      IC_RESPOND: begin
        state_d = IC_IDLE;
      end
      default: begin
        state_d = IC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= IC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word select reads the store, which already holds the filled line in RESPOND
  assign o_ack   = (state_q == IC_RESPOND);
  assign o_rdata = cur_line[{req_offset[OFFSET_W-1:2], 5'b0} +: 32];

  always_comb begin
    o_mem_req       = '0;
    o_mem_req.valid = (state_q == IC_FILL);
    o_mem_req.op    = `MEM_OP_READ;
    o_mem_req.addr  = {req_tag, req_index, {OFFSET_W{1'b0}}};
  end

endmodule

//--- source/cache_line_store.sv
/* Storage of one direct-mapped cache. Reads are combinational at i_index.
   A write replaces metadata and line together; reset clears only the metadata. */

`include "cache_params.svh"

module cache_line_store (
  input  logic                  clk,
  input  logic                  i_rst,
  input  cache_pkg::index_t     i_index,
  output cache_pkg::line_meta_t o_meta,
  output cache_pkg::line_t      o_line,
  input  logic                  i_wr_en,
  input  cache_pkg::line_meta_t i_wr_meta,
  input  cache_pkg::line_t      i_wr_line
);

  import cache_pkg::*;

  line_meta_t meta_q [`CACHE_LINES];
  line_t      data_q [`CACHE_LINES];

  assign o_meta = meta_q[i_index];
  assign o_line = data_q[i_index];

  // ==================================================
  // Metadata array
  // ==================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        meta_q[i] <= '0;              // All lines invalid and clean
      end
    end else if (i_wr_en) begin
      meta_q[i_index] <= i_wr_meta;
    end
  end

  // ==================================================
  // Data array
  // ==================================================
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      data_q[i_index] <= i_wr_line;
    end
  end

endmodule

//--- source/cache_pkg.sv
/* Types shared by the cache unit. Widths follow the geometry macros. */

package cache_pkg;

`include "cache_params.svh"

  localparam int OFFSET_W = $clog2(`LINE_BYTES);
  localparam int INDEX_W  = $clog2(`CACHE_LINES);
  localparam int TAG_W    = `ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [`ADDR_W-1:0]       addr_t;
  typedef logic [`LINE_BYTES*8-1:0] line_t;
  typedef logic [63:0]              dword_t;
  typedef logic [31:0]              inst_t;
  typedef logic [OFFSET_W-1:0]      offset_t;
  typedef logic [INDEX_W-1:0]       index_t;
  typedef logic [TAG_W-1:0]         tag_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } line_meta_t;

  typedef struct packed {
    logic  valid;
    logic  op;        // MEM_OP_READ or MEM_OP_WRITE
    addr_t addr;      // Always line aligned
    line_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ready;     // One-cycle pulse ending the transfer
    line_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {IC_IDLE, IC_FILL, IC_RESPOND} icache_state_t;
  typedef enum logic [1:0] {DC_IDLE, DC_EVICT, DC_FILL, DC_RESPOND} dcache_state_t;

endpackage

//--- source/cache_params.svh
/* Geometry shared by both L1 caches and the op codes of the memory bus.
   Line and cache sizes must stay powers of two, the address split is derived from them. */

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ==================================================
// Cache geometry
// ==================================================
`define CACHE_LINES   16      // Lines per cache, direct-mapped
`define LINE_BYTES    64      // Bytes per line, one bus transfer
`define ADDR_W        64      // Byte address width

// ==================================================
// Memory bus operations
// ==================================================
`define MEM_OP_READ   1'b0
`define MEM_OP_WRITE  1'b1

`endif
